//--- sources.f
hw/line_pkg.sv
hw/cacheline_adaptor.sv
hw/burst_mem.sv
hw/mem_cfg_regs.sv
hw/line_mem_top.sv
bench/line_mem_asserts.sv
bench/line_mem_tb.sv

//--- bench/line_mem_tb.sv
`timescale 1ns/1ps

module line_mem_tb;
    import line_pkg::*;

    localparam int TIMEOUT = 200;  // cycles, well above the 66-cycle worst line

    logic     clk;
    logic     reset_n;
    addr_t    address;
    line_t    line_in;
    logic     read;
    logic     write;
    line_t    line_out;
    logic     resp;
    logic     cfg_req;
    cfg_req_t cfg;
    logic     cfg_ack;
    cnt_t     cfg_rdata;

    logic [31:0] lfsr_state;
    line_t       model [MEM_LINES];  // expected contents per line index
    logic [5:0]  known_idx;
    int          n_reads;
    int          n_writes;

    line_mem_top dut0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .address_i   (address),
        .line_i      (line_in),
        .read_i      (read),
        .write_i     (write),
        .line_o      (line_out),
        .resp_o      (resp),
        .cfg_req_i   (cfg_req),
        .cfg_i       (cfg),
        .cfg_ack_o   (cfg_ack),
        .cfg_rdata_o (cfg_rdata)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        int    k;
        for (k = 0; k < LINE_W / 32; k++) begin
            l[32*k +: 32] = rand_bits(32);
        end
        return l;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] expected,
                               input logic [LINE_W-1:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("** Error at %0t: %s expected %0h, got %0h",
                               $time, name, expected, actual));
        end
    endtask

    // edges counted after the one that samples the request
    task automatic wait_resp(input string what, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!resp) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("timeout: resp_o never came for the line %s", what));
            end
            @(negedge clk);
        end
    endtask

    task automatic cache_write(input addr_t a, input line_t l);
        int cycles;
        @(negedge clk);
        address = a;
        line_in = l;
        write   = 1'b1;
        wait_resp("write", cycles);
        write   = 1'b0;
        n_writes++;
    endtask

    task automatic cache_read(input addr_t a, output line_t l, output int latency);
        @(negedge clk);
        address = a;
        read    = 1'b1;
        wait_resp("read", latency);
        l       = line_out;
        read    = 1'b0;
        n_reads++;
    endtask

    task automatic cfg_access(input cfg_addr_t a, input logic wr, input cnt_t d,
                              output cnt_t rdata);
        int cycles;
        @(negedge clk);
        cfg.addr  = a;
        cfg.wr    = wr;
        cfg.wdata = d;
        cfg_req   = 1'b1;
        cycles    = 0;
        @(negedge clk);
        while (!cfg_ack) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("timeout: cfg_ack_o never rose for the register access");
            end
            @(negedge clk);
        end
        rdata   = cfg_rdata;
        cfg_req = 1'b0;
        cycles  = 0;
        @(negedge clk);
        while (cfg_ack) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("timeout: cfg_ack_o stayed high after the request dropped");
            end
            @(negedge clk);
        end
    endtask

    task automatic cfg_write(input cfg_addr_t a, input cnt_t d);
        cnt_t unused;
        cfg_access(a, 1'b1, d, unused);
    endtask

    task automatic cfg_read(input cfg_addr_t a, output cnt_t d);
        cfg_access(a, 1'b0, '0, d);
    endtask

    task automatic reset_state();
        cnt_t v;
        check_value("resp_o", '0, resp);
        check_value("cfg_ack_o", '0, cfg_ack);
        cfg_read(REG_WAIT, v);
        check_value("REG_WAIT", '0, v);
        cfg_read(REG_READS, v);
        check_value("REG_READS", '0, v);
        cfg_read(REG_WRITES, v);
        check_value("REG_WRITES", '0, v);
    endtask

    task automatic write_read_back();
        addr_t a;
        line_t l;
        line_t got;
        int    lat;
        a      = rand_bits(32);
        a[4:0] = '0;
        l      = rand_line();
        cache_write(a, l);
        model[a[10:5]] = l;
        known_idx      = a[10:5];
        a[4:0] = 5'(rand_bits(5)) | 5'd1;  // offset inside the line must be ignored
        cache_read(a, got, lat);
        check_value("line_o", l, got);
    endtask

    task automatic many_lines();
        logic [5:0] idx [8];
        logic [5:0] start;
        addr_t      a;
        line_t      l;
        line_t      got;
        int         lat;
        int         k;
        start = 6'(rand_bits(6));
        for (k = 0; k < 8; k++) begin
            idx[k]  = start + 6'(9 * k);  // stride 9 is coprime with 64
            l       = rand_line();
            a       = rand_bits(32);
            a[10:5] = idx[k];
            a[4:0]  = '0;
            cache_write(a, l);
            model[idx[k]] = l;
        end
        for (k = 7; k >= 0; k--) begin
            a       = rand_bits(32);
            a[10:5] = idx[k];
            cache_read(a, got, lat);
            check_value($sformatf("line_o[idx %0d]", idx[k]), model[idx[k]], got);
        end
    endtask

    task automatic wait_latency();
        int    w;
        int    j;
        int    lat;
        cnt_t  v;
        addr_t a;
        line_t got;
        for (j = 0; j < 3; j++) begin
            w = (j == 0) ? 0 : (j == 1) ? 3 : 15;
            cfg_write(REG_WAIT, cnt_t'(w));
            cfg_read(REG_WAIT, v);
            check_value("REG_WAIT", w, v);
            a       = rand_bits(32);
            a[10:5] = known_idx;
            cache_read(a, got, lat);
            check_value("line_o", model[known_idx], got);
            check_value("read latency", 4 * (w + 1) + 2, lat);
        end
        cfg_write(REG_WAIT, '0);
    endtask

    task automatic statistics();
        cnt_t v;
        cfg_read(REG_READS, v);
        check_value("REG_READS", n_reads, v);
        cfg_read(REG_WRITES, v);
        check_value("REG_WRITES", n_writes, v);
        cfg_write(REG_READS, 16'(rand_bits(16)) | 16'd1);  // any data clears
        cfg_read(REG_READS, v);
        check_value("REG_READS", '0, v);
        cfg_read(REG_WRITES, v);
        check_value("REG_WRITES", n_writes, v);
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        address    = '0;
        line_in    = '0;
        read       = 1'b0;
        write      = 1'b0;
        cfg_req    = 1'b0;
        cfg        = '0;
        lfsr_state = 32'h97ff088e;
        known_idx  = '0;
        n_reads    = 0;
        n_writes   = 0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        reset_state();
        write_read_back();
        many_lines();
        wait_latency();
        statistics();

        $display("NO ERRORS");
        $finish;
    end

endmodule : line_mem_tb

//--- bench/line_mem_asserts.sv
`timescale 1ns/1ps

module line_mem_asserts #(
    parameter bit ADAPTOR_CHECKS = 1'b1
) (
    input logic                 clk,
    input logic                 reset_n,
    input logic                 resp_i,
    input logic                 cmd_read_i,
    input logic                 cmd_write_i,
    input line_pkg::beat_idx_t  beat_cnt_i,
    input logic                 cfg_req_i,
    input logic                 cfg_ack_i
);
    import line_pkg::*;

    if (ADAPTOR_CHECKS) begin : g_adaptor
        resp_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
            resp_i |=> !resp_i)
            else $error("resp_o high for more than one cycle");

        cmd_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
            !(cmd_read_i && cmd_write_i))
            else $error("read and write commands high together");

        beat_cnt_range: assert property (@(posedge clk) disable iff (!reset_n)
            beat_cnt_i <= beat_idx_t'(BEATS))
            else $error("beat counter beyond the last beat");
    end else begin : g_cfg
        // request must be present at the edge that raises ack
        ack_after_req: assert property (@(posedge clk) disable iff (!reset_n)
            $rose(cfg_ack_i) |-> $past(cfg_req_i))
            else $error("cfg_ack_o rose without a pending request");
    end

endmodule : line_mem_asserts

bind cacheline_adaptor line_mem_asserts #(.ADAPTOR_CHECKS(1'b1)) adaptor_checks0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .resp_i      (resp_o),
    .cmd_read_i  (mem_req_o.read),
    .cmd_write_i (mem_req_o.write),
    .beat_cnt_i  (beat_cnt),
    .cfg_req_i   (1'b0),
    .cfg_ack_i   (1'b0)
);

bind mem_cfg_regs line_mem_asserts #(.ADAPTOR_CHECKS(1'b0)) cfg_checks0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .resp_i      (1'b0),
    .cmd_read_i  (1'b0),
    .cmd_write_i (1'b0),
    .beat_cnt_i  (3'd0),
    .cfg_req_i   (cfg_req_i),
    .cfg_ack_i   (cfg_ack_o)
);

//--- hw/line_mem_top.sv
`timescale 1ns/1ps

module line_mem_top (
    input  logic               clk,
    input  logic               reset_n,

    // cache port
    input  line_pkg::addr_t    address_i,
    input  line_pkg::line_t    line_i,
    input  logic               read_i,
    input  logic               write_i,
    output line_pkg::line_t    line_o,
    output logic               resp_o,

    // configuration port
    input  logic               cfg_req_i,
    input  line_pkg::cfg_req_t cfg_i,
    output logic               cfg_ack_o,
    output line_pkg::cnt_t     cfg_rdata_o
);
    import line_pkg::*;

    burst_req_t mem_req;
    logic       beat_resp;
    beat_t      rdata;
    wait_t      wait_states;
    logic       line_read_done;
    logic       line_write_done;

    cacheline_adaptor adaptor0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .address_i   (address_i),
        .line_i      (line_i),
        .read_i      (read_i),
        .write_i     (write_i),
        .line_o      (line_o),
        .resp_o      (resp_o),
        .mem_req_o   (mem_req),
        .beat_resp_i (beat_resp),
        .rdata_i     (rdata)
    );

    burst_mem mem0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .mem_req_i         (mem_req),
        .wait_states_i     (wait_states),
        .beat_resp_o       (beat_resp),
        .rdata_o           (rdata),
        .line_read_done_o  (line_read_done),
        .line_write_done_o (line_write_done)
    );

    mem_cfg_regs cfg0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .cfg_req_i         (cfg_req_i),
        .cfg_i             (cfg_i),
        .cfg_ack_o         (cfg_ack_o),
        .cfg_rdata_o       (cfg_rdata_o),
        .line_read_done_i  (line_read_done),
        .line_write_done_i (line_write_done),
        .wait_states_o     (wait_states)
    );

endmodule : line_mem_top

//--- hw/mem_cfg_regs.sv
`timescale 1ns/1ps

module mem_cfg_regs (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               cfg_req_i,
    input  line_pkg::cfg_req_t cfg_i,
    output logic               cfg_ack_o,
    output line_pkg::cnt_t     cfg_rdata_o,
    input  logic               line_read_done_i,
    input  logic               line_write_done_i,
    output line_pkg::wait_t    wait_states_o
);
    import line_pkg::*;

    typedef enum logic [1:0] {
        CFG_IDLE,
        CFG_ACCESS,
        CFG_ACK,
        CFG_RELEASE
    } cfg_state_t;

    cfg_state_t state;
    wait_t      wait_q;
    cnt_t       reads_q;
    cnt_t       writes_q;
    cnt_t       rdata_q;
    logic       clr_reads;
    logic       clr_writes;

    // counter clears only happen in the access cycle
    assign clr_reads  = (state == CFG_ACCESS) && cfg_i.wr && (cfg_i.addr == REG_READS);
    assign clr_writes = (state == CFG_ACCESS) && cfg_i.wr && (cfg_i.addr == REG_WRITES);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= CFG_IDLE;
            cfg_ack_o <= 1'b0;
            wait_q    <= '0;
        end else begin
            unique case (state)
                CFG_IDLE: begin
                    if (cfg_req_i) begin
                        state <= CFG_ACCESS;
                    end
                end
                CFG_ACCESS: begin
                    if (cfg_i.wr && cfg_i.addr == REG_WAIT) begin
                        wait_q <= cfg_i.wdata[WAIT_W-1:0];
                    end
                    cfg_ack_o <= 1'b1;
                    state     <= CFG_ACK;
                end
                CFG_ACK: begin
                    if (!cfg_req_i) begin
                        state <= CFG_RELEASE;
                    end
                end
                CFG_RELEASE: begin
                    cfg_ack_o <= 1'b0;
                    state     <= CFG_IDLE;
                end
                default: begin
                    state <= CFG_IDLE;
                end
            endcase
        end
    end

    // statistics, saturating
    always_ff @(posedge clk) begin
        if (!reset_n || clr_reads) begin
            reads_q <= '0;
        end else if (line_read_done_i && reads_q != '1) begin
            reads_q <= reads_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || clr_writes) begin
            writes_q <= '0;
        end else if (line_write_done_i && writes_q != '1) begin
            writes_q <= writes_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == CFG_ACCESS) begin
            unique case (cfg_i.addr)
                REG_WAIT:   rdata_q <= cnt_t'(wait_q);
                REG_READS:  rdata_q <= reads_q;
                REG_WRITES: rdata_q <= writes_q;
                default:    rdata_q <= '0;  // unmapped
            endcase
        end
    end

    assign cfg_rdata_o   = rdata_q;
    assign wait_states_o = wait_q;

endmodule : mem_cfg_regs

//--- hw/burst_mem.sv
`timescale 1ns/1ps

module burst_mem (
    input  logic                 clk,
    input  logic                 reset_n,
    input  line_pkg::burst_req_t mem_req_i,
    input  line_pkg::wait_t      wait_states_i,
    output logic                 beat_resp_o,
    output line_pkg::beat_t      rdata_o,
    output logic                 line_read_done_o,
    output logic                 line_write_done_o
);
    import line_pkg::*;

    localparam int LINE_IDX_W = $clog2(MEM_LINES);
    localparam int MEM_IDX_W  = $clog2(MEM_LINES * BEATS);

    beat_t mem_arr [MEM_LINES*BEATS];

    logic                  active;
    logic [LINE_IDX_W-1:0] line_idx;
    logic [MEM_IDX_W-1:0]  mem_idx;
    beat_idx_t             beat_idx;   // beats completed in this line
    beat_idx_t             issued;     // completed plus the one on the bus
    wait_t                 wait_cnt;
    wait_t                 wait_q;     // setting held for the current beat
    logic                  last_beat;

    assign active   = mem_req_i.read | mem_req_i.write;
    assign line_idx = mem_req_i.addr[5 +: LINE_IDX_W];
    assign mem_idx  = {line_idx, beat_idx[1:0]};
    assign issued   = beat_idx + beat_idx_t'(beat_resp_o);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            beat_resp_o <= 1'b0;
            beat_idx    <= '0;
            wait_cnt    <= '0;
            wait_q      <= '0;
        end else if (!active) begin
            // between lines, restart the beat sequence
            beat_resp_o <= 1'b0;
            beat_idx    <= '0;
            wait_cnt    <= '0;
            wait_q      <= wait_states_i;
        end else begin
            if (beat_resp_o) begin
                beat_idx <= beat_idx + 1'b1;
            end

            if (issued == beat_idx_t'(BEATS)) begin
                beat_resp_o <= 1'b0;  // line finished, wait for command drop
            end else if (wait_cnt == wait_q) begin
                beat_resp_o <= 1'b1;
                wait_cnt    <= '0;
                wait_q      <= wait_states_i; // new setting starts with next beat
            end else begin
                beat_resp_o <= 1'b0;
                wait_cnt    <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_resp_o && mem_req_i.write) begin
            mem_arr[mem_idx] <= mem_req_i.wdata;
        end
    end

    assign rdata_o = mem_arr[mem_idx];

    assign last_beat         = beat_resp_o && (beat_idx == beat_idx_t'(BEATS - 1));
    assign line_read_done_o  = last_beat && mem_req_i.read;
    assign line_write_done_o = last_beat && mem_req_i.write;

endmodule : burst_mem

//--- hw/cacheline_adaptor.sv
`timescale 1ns/1ps

module cacheline_adaptor (
    input  logic                 clk,
    input  logic                 reset_n,

    // cache side
    input  line_pkg::addr_t      address_i,
    input  line_pkg::line_t      line_i,
    input  logic                 read_i,
    input  logic                 write_i,
    output line_pkg::line_t      line_o,
    output logic                 resp_o,

    // burst memory side
    output line_pkg::burst_req_t mem_req_o,
    input  logic                 beat_resp_i,
    input  line_pkg::beat_t      rdata_i
);
    import line_pkg::*;

    adaptor_state_t state;
    adaptor_state_t next_state;
    beat_idx_t      beat_cnt;
    beat_idx_t      beat_cnt_next;
    line_t          line_q;
    logic [1:0]     slot;

    assign slot = beat_cnt[1:0]; // beat position inside the line

    always_comb begin
        next_state    = state;
        beat_cnt_next = beat_cnt;

        unique case (state)
            IDLE: begin
                beat_cnt_next = '0;
                if (read_i) begin
                    next_state = READ;
                end else if (write_i) begin
                    next_state = WRITE;
                end
            end

            READ,
            WRITE: begin
                if (beat_cnt == beat_idx_t'(BEATS)) begin
                    next_state = DONE;
                end else if (beat_resp_i) begin
                    beat_cnt_next = beat_cnt + 1'b1;
                end
                // otherwise hold the count until the next beat arrives
            end

            DONE: begin
                next_state = IDLE;
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            state    <= next_state;
            beat_cnt <= beat_cnt_next;
        end
    end

    // read beats land in their slot of the line register
    always_ff @(posedge clk) begin
        if (state == READ && beat_resp_i) begin
            line_q[BEAT_W*slot +: BEAT_W] <= rdata_i;
        end
    end

    always_comb begin
        mem_req_o       = '0;
        mem_req_o.addr  = {address_i[ADDR_W-1:5], 5'b0}; // 32-byte line aligned
        mem_req_o.read  = (state == READ);
        mem_req_o.write = (state == WRITE);
        mem_req_o.wdata = line_i[BEAT_W*slot +: BEAT_W];
    end

    assign resp_o = (state == DONE);
    assign line_o = line_q;

endmodule : cacheline_adaptor

//--- hw/line_pkg.sv
package line_pkg;

    localparam int LINE_W    = 256;
    localparam int BEAT_W    = 64;
    localparam int BEATS     = 4;
    localparam int ADDR_W    = 32;
    localparam int MEM_LINES = 64;
    localparam int WAIT_W    = 4;
    localparam int CNT_W     = 16;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [2:0]        beat_idx_t;  // must reach BEATS
    typedef logic [WAIT_W-1:0] wait_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [1:0]        cfg_addr_t;

    // register map
    localparam cfg_addr_t REG_WAIT   = 2'd0;
    localparam cfg_addr_t REG_READS  = 2'd1;
    localparam cfg_addr_t REG_WRITES = 2'd2;

    typedef struct packed {
        cfg_addr_t addr;
        logic      wr;
        cnt_t      wdata;
    } cfg_req_t;

    typedef struct packed {
        addr_t addr;
        logic  read;
        logic  write;
        beat_t wdata;
    } burst_req_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        DONE
    } adaptor_state_t;

endpackage : line_pkg
